// File: dv/bepipe_tb.sv
module bepipe_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import bepipe_pkg::*;

    localparam int ram_words    = 256;
    localparam int mem_aw       = $clog2(ram_words) + 3;   // byte address bits
    localparam int max_cycles   = 2000;
    localparam int drain_cycles = 4;                       // accept, stage, write, margin

    logic        clk;
    logic        rst;
    logic        ex_valid;
    ex_to_ms_t   ex_bus;
    logic        ex_allowin;
    reg_addr_t   raddr1;
    reg_addr_t   raddr2;
    logic [63:0] rdata1;
    logic [63:0] rdata2;

    logic [63:0] model_regs [32];
    logic [7:0]  model_mem [ram_words*8];                 // byte image of data_ram
    string       test_name;
    int          cycles;

    bepipe_top #(.ram_words(ram_words)) bepipe_top_i (
        .clk        (clk),
        .rst        (rst),
        .ex_valid   (ex_valid),
        .ex_bus     (ex_bus),
        .ex_allowin (ex_allowin),
        .raddr1     (raddr1),
        .raddr2     (raddr2),
        .rdata1     (rdata1),
        .rdata2     (rdata2)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout, the run did not end within %0d cycles", max_cycles);
            $display(">>> FAIL");
            $fatal(1, "timeout");
        end
    end

    task automatic check(string name, logic [63:0] expected, logic [63:0] actual);
        if (actual !== expected) begin
            $display("Fail %s expected %h actual %h", name, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic int op_size(mem_op_e op);
        case (op)
            mem_lb, mem_lbu, mem_sb: return 1;
            mem_lh, mem_lhu, mem_sh: return 2;
            mem_lw, mem_lwu, mem_sw: return 4;
            mem_ld, mem_sd:          return 8;
            default:                 return 0;
        endcase
    endfunction

    function automatic ex_to_ms_t make_item(logic wen, reg_addr_t rd, wreg_sel_e sel,
                                            mem_op_e op, logic [63:0] alu,
                                            logic [63:0] sdata, logic [63:0] pc);
        ex_to_ms_t it;
        it.inst       = 32'h0000_0013;
        it.pc         = pc;
        it.reg_wen    = wen;
        it.rd         = rd;
        it.wreg_sel   = sel;
        it.mem_op     = op;
        it.alu_result = alu;
        it.store_data = sdata;
        return it;
    endfunction

    // items are applied in send order, which the pipeline keeps
    task automatic model_apply(ex_to_ms_t it);
        logic [mem_aw-1:0] base;
        logic [63:0]       ld;
        logic [63:0]       wdata;
        int                size;
        base = it.alu_result[mem_aw-1:0];
        size = op_size(it.mem_op);
        ld   = '0;
        if (it.mem_op inside {mem_sb, mem_sh, mem_sw, mem_sd}) begin
            for (int k = 0; k < size; k++) begin
                model_mem[base + mem_aw'(k)] = it.store_data[k*8 +: 8];   // little endian
            end
        end else if (size != 0) begin
            for (int k = 0; k < size; k++) begin
                ld[k*8 +: 8] = model_mem[base + mem_aw'(k)];
            end
            if ((it.mem_op inside {mem_lb, mem_lh, mem_lw}) && ld[size*8-1]) begin
                ld = ld | ~((64'd1 << (size*8)) - 64'd1);             // sign fill
            end
        end
        case (it.wreg_sel)
            wreg_alu: wdata = it.alu_result;
            wreg_ram: wdata = ld;
            wreg_pc:  wdata = it.pc + 64'd4;
            default:  wdata = '0;
        endcase
        if (it.reg_wen && it.rd != 5'd0) begin
            model_regs[it.rd] = wdata;
        end
    endtask

    task automatic send(ex_to_ms_t it);
        @(posedge clk);
        #1;
        ex_bus   = it;
        ex_valid = 1'b1;
        while (!ex_allowin) begin                       // hold until the stage takes it
            @(posedge clk);
            #1;
        end
        model_apply(it);
    endtask

    task automatic idle(int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            ex_valid = 1'b0;
        end
    endtask

    task automatic alu_write(reg_addr_t rd, logic [63:0] value);
        send(make_item(1'b1, rd, wreg_alu, mem_none, value, '0, '0));
    endtask

    task automatic link_write(reg_addr_t rd, logic [63:0] pc);
        send(make_item(1'b1, rd, wreg_pc, mem_none, '0, '0, pc));
    endtask

    task automatic store_to(mem_op_e op, logic [63:0] addr, logic [63:0] data);
        send(make_item(1'b0, 5'd0, wreg_alu, op, addr, data, '0));
    endtask

    task automatic load_from(mem_op_e op, reg_addr_t rd, logic [63:0] addr);
        send(make_item(1'b1, rd, wreg_ram, op, addr, '0, '0));
    endtask

    task automatic read_all();
        for (int r = 0; r < 32; r++) begin
            raddr1 = reg_addr_t'(r);
            raddr2 = reg_addr_t'(r);
            #1;
            check($sformatf("%s x%0d port 1", test_name, r), model_regs[r], rdata1);
            check($sformatf("%s x%0d port 2", test_name, r), model_regs[r], rdata2);
        end
    endtask

    task automatic alu_writeback();
        test_name = "alu";
        check("alu allowin after reset", 64'd1, 64'(ex_allowin));
        read_all();                                     // all zero out of reset
        alu_write(5'd1, 64'h0123_4567_89ab_cdef);
        alu_write(5'd2, 64'hffff_ffff_ffff_ffff);
        alu_write(5'd3, 64'h8000_0000_0000_0000);
        alu_write(5'd0, 64'hdead_beef_dead_beef);       // x0 must stay zero
        alu_write(5'd31, 64'h0000_0000_0000_002a);
        alu_write(5'd1, 64'h5555_aaaa_5555_aaaa);
        idle(drain_cycles);
        read_all();
    endtask

    task automatic link_writeback();
        test_name = "link";
        link_write(5'd10, 64'h0000_0000_8000_0000);
        link_write(5'd11, 64'hffff_ffff_ffff_fffc);     // wraps to zero
        link_write(5'd12, 64'hffff_ffff_ffff_fffe);
        link_write(5'd9, 64'h7fff_ffff_ffff_fffc);
        link_write(5'd0, 64'h0000_0000_0000_1000);
        idle(drain_cycles);
        read_all();
    endtask

    task automatic load_store_sizes();
        test_name = "load store";
        store_to(mem_sd, 64'h100, 64'h8899_aabb_ccdd_eeff);
        store_to(mem_sd, 64'h108, 64'hf0e1_d2c3_b4a5_9687);
        store_to(mem_sd, 64'h110, 64'h0011_2233_4455_6677);
        store_to(mem_sd, 64'h118, 64'hfedc_ba98_7654_3210);
        store_to(mem_sb, 64'h103, 64'h0000_0000_0000_00a5);
        store_to(mem_sh, 64'h10c, 64'h0000_0000_0000_8001);
        store_to(mem_sw, 64'h110, 64'h0000_0000_9abc_def0);
        store_to(mem_sh, 64'h116, 64'h0000_0000_0000_c0de);
        load_from(mem_lb, 5'd13, 64'h103);
        load_from(mem_lbu, 5'd14, 64'h103);
        load_from(mem_lh, 5'd15, 64'h10c);
        load_from(mem_lhu, 5'd16, 64'h10c);
        load_from(mem_lw, 5'd17, 64'h110);
        load_from(mem_lwu, 5'd18, 64'h110);
        load_from(mem_ld, 5'd19, 64'h100);
        load_from(mem_ld, 5'd20, 64'h118);
        load_from(mem_lh, 5'd21, 64'h116);
        load_from(mem_lb, 5'd22, 64'h107);
        load_from(mem_lw, 5'd26, 64'h114);              // straddles two stores
        idle(drain_cycles);
        read_all();
    endtask

    task automatic write_enable_off();
        test_name = "write enable off";
        alu_write(5'd23, 64'h1111_2222_3333_4444);
        alu_write(5'd24, 64'h5555_6666_7777_8888);
        send(make_item(1'b0, 5'd23, wreg_alu, mem_none, 64'hbad0_bad0_bad0_bad0, '0, '0));
        send(make_item(1'b0, 5'd24, wreg_pc, mem_none, '0, '0, 64'h4000));
        send(make_item(1'b0, 5'd23, wreg_alu, mem_sd, 64'h200, 64'hcafe_f00d_8765_4321, '0));
        send(make_item(1'b0, 5'd24, wreg_ram, mem_ld, 64'h200, '0, '0));
        load_from(mem_ld, 5'd25, 64'h200);
        load_from(mem_lw, 5'd27, 64'h204);
        idle(drain_cycles);
        read_all();
    endtask

    task automatic back_to_back_stream();
        int                sent;
        int                kind;
        reg_addr_t         rd;
        logic [mem_aw-1:0] dw;
        mem_op_e           ld_op;
        logic [63:0]       off;
        test_name = "stream";
        sent      = 0;
        while (sent < 64) begin
            kind = int'($urandom % 3);
            rd   = reg_addr_t'($urandom % 32);
            if (kind == 2 && sent < 63) begin
                dw    = mem_aw'(32'h300 + ($urandom % 16) * 8);
                ld_op = mem_op_e'(int'(mem_lb) + int'($urandom % 7));
                off   = 64'($urandom % 8) & ~64'(op_size(ld_op) - 1);   // size aligned
                store_to(mem_sd, 64'(dw), {$urandom, $urandom});
                load_from(ld_op, rd, 64'(dw) + off);
                sent += 2;
            end else if (kind == 1) begin
                link_write(rd, {$urandom, $urandom});
                sent += 1;
            end else begin
                alu_write(rd, {$urandom, $urandom});
                sent += 1;
            end
        end
        idle(drain_cycles);
        read_all();
    endtask

    initial begin
        void'($urandom(27));
        rst      = 1'b1;
        ex_valid = 1'b0;
        ex_bus   = '0;
        raddr1   = '0;
        raddr2   = '0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        alu_writeback();
        link_writeback();
        load_store_sizes();
        write_enable_off();
        back_to_back_stream();
        $display(">>> PASS");
        $finish;
    end

endmodule

// File: filelist.f
src/bepipe_pkg.sv
src/data_ram.sv
src/mem_stage.sv
src/wb_stage.sv
src/reg_file.sv
src/bepipe_top.sv
dv/bepipe_tb.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module bepipe_tb -Mdir obj_dir -o bepipe_sim -f filelist.f \
    && ./obj_dir/bepipe_sim 2>&1 | tee sim.log \
    || { echo "build or simulation did not complete"; exit 1; }
grep -q ">>> FAIL" sim.log && { echo "test failed"; exit 1; }
echo "test passed"
exit 0

// File: src/bepipe_pkg.sv
package bepipe_pkg;

    localparam int xlen = 64;                  // RV64 data and pc width

    typedef logic [4:0] reg_addr_t;

    typedef enum logic [1:0] {wreg_alu, wreg_ram, wreg_pc} wreg_sel_e;

    typedef enum logic [3:0] {
        mem_none,
        mem_lb, mem_lbu, mem_lh, mem_lhu, mem_lw, mem_lwu, mem_ld,
        mem_sb, mem_sh, mem_sw, mem_sd
    } mem_op_e;

    function automatic logic is_load(mem_op_e op);
        return op inside {mem_lb, mem_lbu, mem_lh, mem_lhu, mem_lw, mem_lwu, mem_ld};
    endfunction

    function automatic logic is_store(mem_op_e op);
        return op inside {mem_sb, mem_sh, mem_sw, mem_sd};
    endfunction

    typedef struct packed {
        logic [31:0]     inst;
        logic [xlen-1:0] pc;
        logic            reg_wen;
        reg_addr_t       rd;
        wreg_sel_e       wreg_sel;
        mem_op_e         mem_op;
        logic [xlen-1:0] alu_result;         // also the memory address
        logic [xlen-1:0] store_data;
    } ex_to_ms_t;

    typedef struct packed {
        logic [31:0]     inst;
        logic [xlen-1:0] pc;
        logic            reg_wen;
        reg_addr_t       rd;
        wreg_sel_e       wreg_sel;
        logic [xlen-1:0] alu_result;
        logic [xlen-1:0] rdata;              // extended load value
    } ms_to_ws_t;

    typedef struct packed {
        logic            wen;
        reg_addr_t       waddr;
        logic [xlen-1:0] wdata;
    } rf_wr_t;

endpackage

// File: src/bepipe_top.sv
module bepipe_top #(
    parameter int ram_words = 256
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  ex_valid,
    input  bepipe_pkg::ex_to_ms_t ex_bus,
    output logic                  ex_allowin,
    input  bepipe_pkg::reg_addr_t raddr1,
    input  bepipe_pkg::reg_addr_t raddr2,
    output logic [63:0]           rdata1,
    output logic [63:0]           rdata2
);
    import bepipe_pkg::*;

    logic                         ms_valid;
    logic                         ws_allowin;
    ms_to_ws_t                    ms_bus;
    rf_wr_t                       rf_wr;
    logic                         ram_en;
    logic                         ram_we;
    logic [$clog2(ram_words)-1:0] ram_addr;
    logic [7:0]                   ram_be;
    logic [63:0]                  ram_wdata;
    logic [63:0]                  ram_rdata;

    mem_stage #(.ram_words(ram_words)) mem_stage_i (
        .clk        (clk),
        .rst        (rst),
        .ex_valid   (ex_valid),
        .ex_bus     (ex_bus),
        .ms_allowin (ex_allowin),
        .ws_allowin (ws_allowin),
        .ms_valid   (ms_valid),
        .ms_bus     (ms_bus),
        .ram_en     (ram_en),
        .ram_we     (ram_we),
        .ram_addr   (ram_addr),
        .ram_be     (ram_be),
        .ram_wdata  (ram_wdata),
        .ram_rdata  (ram_rdata)
    );

    data_ram #(.ram_words(ram_words)) data_ram_i (
        .clk   (clk),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .be    (ram_be),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    wb_stage wb_stage_i (
        .clk        (clk),
        .rst        (rst),
        .ms_valid   (ms_valid),
        .ms_bus     (ms_bus),
        .ws_allowin (ws_allowin),
        .rf_wr      (rf_wr)
    );

    reg_file reg_file_i (
        .clk    (clk),
        .rst    (rst),
        .rf_wr  (rf_wr),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

endmodule

// File: src/data_ram.sv
module data_ram #(
    parameter int ram_words = 256
) (
    input  logic                         clk,
    input  logic                         en,
    input  logic                         we,
    input  logic [$clog2(ram_words)-1:0] addr,
    input  logic [7:0]                   be,
    input  logic [63:0]                  wdata,
    output logic [63:0]                  rdata
);

    // doubleword storage, one byte lane per be bit
    logic [63:0] mem [ram_words];

    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                for (int b = 0; b < 8; b++) begin
                    if (be[b]) begin
                        mem[addr][b*8 +: 8] <= wdata[b*8 +: 8];   // byte lane write
                    end
                end
            end
            rdata <= mem[addr];                   // old data on a write cycle
        end
    end

endmodule

// File: src/mem_stage.sv
module mem_stage #(
    parameter int ram_words = 256
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         ex_valid,
    input  bepipe_pkg::ex_to_ms_t        ex_bus,
    output logic                         ms_allowin,
    input  logic                         ws_allowin,
    output logic                         ms_valid,
    output bepipe_pkg::ms_to_ws_t        ms_bus,
    output logic                         ram_en,
    output logic                         ram_we,
    output logic [$clog2(ram_words)-1:0] ram_addr,
    output logic [7:0]                   ram_be,
    output logic [63:0]                  ram_wdata,
    input  logic [63:0]                  ram_rdata
);
    import bepipe_pkg::*;

    localparam int addr_w = $clog2(ram_words);

    ex_to_ms_t       ms_r;
    logic            ms_ready_go;
    logic            ms_accept;
    logic [2:0]      st_off;
    logic [2:0]      ld_off;
    logic [7:0]      ld_byte;
    logic [15:0]     ld_half;
    logic [31:0]     ld_word;
    logic [xlen-1:0] ld_data;

    assign ms_ready_go = 1'b1;                    // memory answers in one cycle
    assign ms_allowin  = !ms_valid || (ms_ready_go && ws_allowin);
    assign ms_accept   = ex_valid && ms_allowin;

    always_ff @(posedge clk) begin
        if (rst) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= ex_valid;
        end
        if (ms_accept) begin
            ms_r <= ex_bus;
        end
    end

    // request goes out in the accepting cycle
    assign st_off   = ex_bus.alu_result[2:0];
    assign ram_en   = ms_accept && (is_load(ex_bus.mem_op) || is_store(ex_bus.mem_op));
    assign ram_we   = ms_accept && is_store(ex_bus.mem_op);
    assign ram_addr = ex_bus.alu_result[3 +: addr_w];   // wraps modulo ram_words

    always_comb begin
        ram_be    = 8'h00;
        ram_wdata = '0;
        case (ex_bus.mem_op)
            mem_sb: begin
                ram_be    = 8'b0000_0001 << st_off;
                ram_wdata = {8{ex_bus.store_data[7:0]}};
            end
            mem_sh: begin
                ram_be    = 8'b0000_0011 << {st_off[2:1], 1'b0};
                ram_wdata = {4{ex_bus.store_data[15:0]}};
            end
            mem_sw: begin
                ram_be    = 8'b0000_1111 << {st_off[2], 2'b00};
                ram_wdata = {2{ex_bus.store_data[31:0]}};
            end
            mem_sd: begin
                ram_be    = 8'hff;
                ram_wdata = ex_bus.store_data;
            end
            default: ;                            // loads and non-memory ops
        endcase
    end

    // lane pick from the registered read data
    assign ld_off  = ms_r.alu_result[2:0];
    assign ld_byte = ram_rdata[{ld_off, 3'b000} +: 8];
    assign ld_half = ram_rdata[{ld_off[2:1], 4'b0000} +: 16];
    assign ld_word = ram_rdata[{ld_off[2], 5'b00000} +: 32];

    always_comb begin
        case (ms_r.mem_op)
            mem_lb:  ld_data = {{56{ld_byte[7]}}, ld_byte};
            mem_lbu: ld_data = {56'b0, ld_byte};
            mem_lh:  ld_data = {{48{ld_half[15]}}, ld_half};
            mem_lhu: ld_data = {48'b0, ld_half};
            mem_lw:  ld_data = {{32{ld_word[31]}}, ld_word};
            mem_lwu: ld_data = {32'b0, ld_word};
            mem_ld:  ld_data = ram_rdata;
            default: ld_data = '0;                // non-loads return zero
        endcase
    end

    assign ms_bus = '{
        inst:       ms_r.inst,
        pc:         ms_r.pc,
        reg_wen:    ms_r.reg_wen,
        rd:         ms_r.rd,
        wreg_sel:   ms_r.wreg_sel,
        alu_result: ms_r.alu_result,
        rdata:      ld_data
    };

    a_valid_after_rst: assert property (@(posedge clk) rst |=> !ms_valid);

    // a memory request belongs to an item that the stage then holds
    a_req_accepted: assert property (@(posedge clk) disable iff (rst)
        ram_en |=> (ms_valid && (is_load(ms_r.mem_op) || is_store(ms_r.mem_op))));

endmodule

// File: src/reg_file.sv
module reg_file (
    input  logic                  clk,
    input  logic                  rst,
    input  bepipe_pkg::rf_wr_t    rf_wr,
    input  bepipe_pkg::reg_addr_t raddr1,
    input  bepipe_pkg::reg_addr_t raddr2,
    output logic [63:0]           rdata1,
    output logic [63:0]           rdata2
);
    import bepipe_pkg::*;

    logic [xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_wr.wen && (rf_wr.waddr != reg_addr_t'(0))) begin
            regs[rf_wr.waddr] <= rf_wr.wdata;     // x0 stays zero
        end
    end

    // plain array reads, no bypass of a same-cycle write
    assign rdata1 = (raddr1 == reg_addr_t'(0)) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == reg_addr_t'(0)) ? '0 : regs[raddr2];

endmodule

// File: src/wb_stage.sv
module wb_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  ms_valid,
    input  bepipe_pkg::ms_to_ws_t ms_bus,
    output logic                  ws_allowin,
    output bepipe_pkg::rf_wr_t    rf_wr
);
    import bepipe_pkg::*;

    ms_to_ws_t       ws_r;
    logic            ws_valid;
    logic            ws_ready_go;
    logic [xlen-1:0] wdata;

    assign ws_ready_go = 1'b1;                    // write-back never stalls
    assign ws_allowin  = !ws_valid || ws_ready_go;

    always_ff @(posedge clk) begin
        if (rst) begin
            ws_valid <= 1'b0;
        end else if (ws_allowin) begin
            ws_valid <= ms_valid;
        end
        if (ms_valid && ws_allowin) begin
            ws_r <= ms_bus;
        end
    end

    // write-back source select
    always_comb begin
        case (ws_r.wreg_sel)
            wreg_alu: wdata = ws_r.alu_result;
            wreg_ram: wdata = ws_r.rdata;
            wreg_pc:  wdata = ws_r.pc + xlen'(4);   // jal/jalr link
            default:  wdata = '0;
        endcase
    end

    assign rf_wr = '{
        wen:   ws_valid && ws_r.reg_wen,
        waddr: ws_r.rd,
        wdata: wdata
    };

    // the select arrives from upstream and must decode
    a_wreg_sel_legal: assert property (@(posedge clk) disable iff (rst)
        ws_valid |-> (ws_r.wreg_sel inside {wreg_alu, wreg_ram, wreg_pc}));

endmodule
